//--- tb.f
+incdir+hdl
hdl/ctrl_bus_pkg.sv
hdl/ctrl_core_pkg.sv
hdl/wb_reg_slave.sv
hdl/ctrl_registers.sv
hdl/core_wake_unit.sv
hdl/cluster_ctrl.sv
bench/cluster_ctrl_checker.sv
bench/cluster_ctrl_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cluster control testbench with Verilator
# the exit status of the simulation is the result of the run
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module cluster_ctrl_tb \
  --Mdir obj_dir \
  -o cluster_ctrl_sim \
  -f tb.f

# a failed assertion is counted and reported by the testbench monitor
./obj_dir/cluster_ctrl_sim +verilator+error+limit+100

//--- bench/cluster_ctrl_tb.sv
// testbench for the cluster control block
// drives the Wishbone port through a table of reads, writes, wake_up writes
// and core acknowledges, then runs a series of random wake_up values
// expected values come from the register map and the wake decode rule

`include "ctrl_params.svh"

module cluster_ctrl_tb
  import ctrl_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ack_timeout  = 16;
  localparam int pend_timeout = 16;
  localparam int num_random   = 32;

  // word offsets of the named registers
  localparam logic [`CTRL_ADDR_WIDTH-3:0] off_eoc   = (`CTRL_ADDR_WIDTH-2)'(EOC);
  localparam logic [`CTRL_ADDR_WIDTH-3:0] off_wake  = (`CTRL_ADDR_WIDTH-2)'(WAKE_UP);
  localparam logic [`CTRL_ADDR_WIDTH-3:0] off_start = (`CTRL_ADDR_WIDTH-2)'(TCDM_START);
  localparam logic [`CTRL_ADDR_WIDTH-3:0] off_end   = (`CTRL_ADDR_WIDTH-2)'(TCDM_END);
  localparam logic [`CTRL_ADDR_WIDTH-3:0] off_cores = (`CTRL_ADDR_WIDTH-2)'(NUM_CORES);

  // constant register contents
  localparam logic [31:0] exp_base  = `CTRL_TCDM_BASE;
  localparam logic [31:0] exp_end   = `CTRL_TCDM_BASE + `CTRL_TCDM_SIZE;
  localparam logic [31:0] exp_cores = `CTRL_NUM_CORES;

  typedef enum {OP_RD, OP_WR, OP_WAKE, OP_ACK, OP_EOC} op_e;

  logic                          clk_i = 1'b0;
  logic                          arst_n_i;
  logic                          wb_cyc_i;
  logic                          wb_stb_i;
  logic                          wb_we_i;
  logic [`CTRL_ADDR_WIDTH-1:0]   wb_adr_i;
  logic [`CTRL_DATA_WIDTH/8-1:0] wb_sel_i;
  logic [`CTRL_DATA_WIDTH-1:0]   wb_dat_i;
  logic [`CTRL_DATA_WIDTH-1:0]   wb_dat_o;
  logic                          wb_ack_o;
  logic [`CTRL_DATA_WIDTH-1:0]   eoc_o;
  logic [`CTRL_NUM_CORES-1:0]    wake_ack_i;
  logic [`CTRL_NUM_CORES-1:0]    wake_pending_o;

  // stimulus table with one entry per index across all columns
  string                          step_name[$];
  op_e                            step_op[$];
  logic [`CTRL_ADDR_WIDTH-3:0]    step_off[$];
  logic [`CTRL_DATA_WIDTH/8-1:0]  step_sel[$];
  logic [`CTRL_DATA_WIDTH-1:0]    step_data[$];
  logic [`CTRL_DATA_WIDTH-1:0]    step_rd[$];
  logic [`CTRL_NUM_CORES-1:0]     step_pend[$];

  logic [31:0] lfsr_state = 32'hd49b;

  cluster_ctrl cluster_ctrl_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_sel_i       (wb_sel_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .eoc_o          (eoc_o),
    .wake_ack_i     (wake_ack_i),
    .wake_pending_o (wake_pending_o)
  );

  // 4 ns period
  always #2 clk_i = ~clk_i;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // a failed assertion in the bound checker ends the run too
  always @(negedge clk_i) begin
    if (cluster_ctrl_i.checker_i.fail_count != 0) begin
      fail_run("an assertion in the bound checker failed");
    end
  end

  // 32-bit Galois LFSR advanced by one shift per call
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // collect n bits from the LFSR with the first bit ending up as msb
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int b = 0; b < n; b++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = galois_step(lfsr_state);
    end
  endtask

  // reference wake decode
  // all ones wakes every core
  // a value below the core count wakes only that core
  // any other value wakes nobody
  function automatic logic [`CTRL_NUM_CORES-1:0] ref_decode(input logic [31:0] v);
    if (v == 32'hffff_ffff) begin
      return '1;
    end
    if (v < `CTRL_NUM_CORES) begin
      return {{(`CTRL_NUM_CORES-1){1'b0}}, 1'b1} << v;
    end
    return '0;
  endfunction

  // returns at the edge that ends the ack cycle
  task automatic wait_ack(input string name);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > ack_timeout) begin
        fail_run($sformatf("no Wishbone ack for %s within %0d cycles", name, ack_timeout));
      end
    end while (!wb_ack_o);
  endtask

  task automatic bus_write(input string name, input logic [`CTRL_ADDR_WIDTH-3:0] off,
                           input logic [3:0] sel, input logic [31:0] data);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b1;
    wb_adr_i <= {off, 2'b00};
    wb_sel_i <= sel;
    wb_dat_i <= data;
    wait_ack(name);
    // master releases the bus in the cycle after ack
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic bus_read(input string name, input logic [`CTRL_ADDR_WIDTH-3:0] off,
                          output logic [31:0] data);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b0;
    wb_adr_i <= {off, 2'b00};
    wb_sel_i <= 4'hf;
    wait_ack(name);
    // read data is valid during the ack cycle
    data = wb_dat_o;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
  endtask

  // one-cycle acknowledge from the selected cores
  task automatic pulse_wake_ack(input logic [`CTRL_NUM_CORES-1:0] mask);
    @(posedge clk_i);
    wake_ack_i <= mask;
    @(posedge clk_i);
    wake_ack_i <= '0;
  endtask

  // wait for the expected flags and then two more edges so a late bit shows up
  task automatic wait_pending(input string name, input logic [`CTRL_NUM_CORES-1:0] expected);
    int cycles;
    cycles = 0;
    while (wake_pending_o !== expected && cycles < pend_timeout) begin
      @(posedge clk_i);
      cycles++;
    end
    repeat (2) @(posedge clk_i);
    check_value({name, " pending"}, 32'(expected), 32'(wake_pending_o));
  endtask

  task automatic add_step(input string name, input op_e op,
                          input logic [`CTRL_ADDR_WIDTH-3:0] off, input logic [3:0] sel,
                          input logic [31:0] data, input logic [31:0] exp_rd,
                          input logic [`CTRL_NUM_CORES-1:0] exp_pend);
    step_name.push_back(name);
    step_op.push_back(op);
    step_off.push_back(off);
    step_sel.push_back(sel);
    step_data.push_back(data);
    step_rd.push_back(exp_rd);
    step_pend.push_back(exp_pend);
  endtask

  task automatic run_step(input int i);
    logic [31:0] rd;
    case (step_op[i])
      OP_RD: begin
        bus_read(step_name[i], step_off[i], rd);
        check_value(step_name[i], step_rd[i], rd);
      end
      OP_WR: bus_write(step_name[i], step_off[i], step_sel[i], step_data[i]);
      OP_WAKE: bus_write(step_name[i], off_wake, step_sel[i], step_data[i]);
      OP_ACK: pulse_wake_ack(step_data[i][`CTRL_NUM_CORES-1:0]);
      OP_EOC: check_value(step_name[i], step_rd[i], eoc_o);
      default: fail_run("unknown operation in the stimulus table");
    endcase
    // pending flags are checked after every step
    wait_pending(step_name[i], step_pend[i]);
    if (step_op[i] == OP_WAKE) begin
      bus_read(step_name[i], off_wake, rd);
      check_value({step_name[i], " readback"}, step_rd[i], rd);
    end
  endtask

  // random wake values that favor small ids and all ones
  task automatic random_wakes(input int count);
    logic [31:0] kind;
    logic [31:0] value;
    logic [31:0] rd;
    string       name;
    for (int n = 0; n < count; n++) begin
      name = $sformatf("random wake %0d", n);
      take_bits(2, kind);
      case (kind[1:0])
        2'd0: take_bits(3, value);
        2'd1: value = 32'hffff_ffff;
        2'd2: take_bits(4, value);
        default: take_bits(32, value);
      endcase
      bus_write(name, off_wake, 4'hf, value);
      wait_pending(name, ref_decode(value));
      bus_read(name, off_wake, rd);
      check_value({name, " readback"}, value, rd);
      pulse_wake_ack('1);
      wait_pending({name, " cleared"}, '0);
    end
  endtask

  initial begin
    arst_n_i   <= 1'b0;
    wb_cyc_i   <= 1'b0;
    wb_stb_i   <= 1'b0;
    wb_we_i    <= 1'b0;
    wb_adr_i   <= '0;
    wb_sel_i   <= '0;
    wb_dat_i   <= '0;
    wake_ack_i <= '0;

    // reset values
    add_step("reset eoc", OP_RD, off_eoc, 4'hf, 32'h0, 32'h0, 8'h00);
    add_step("reset wake_up", OP_RD, off_wake, 4'hf, 32'h0, 32'h0, 8'h00);
    add_step("reset tcdm_start", OP_RD, off_start, 4'hf, 32'h0, exp_base, 8'h00);
    add_step("reset tcdm_end", OP_RD, off_end, 4'hf, 32'h0, exp_end, 8'h00);
    add_step("reset num_cores", OP_RD, off_cores, 4'hf, 32'h0, exp_cores, 8'h00);
    add_step("reset eoc_o", OP_EOC, off_eoc, 4'hf, 32'h0, 32'h0, 8'h00);
    // eoc byte lanes
    add_step("eoc full write", OP_WR, off_eoc, 4'hf, 32'hdead_beef, 32'h0, 8'h00);
    add_step("eoc full read", OP_RD, off_eoc, 4'hf, 32'h0, 32'hdead_beef, 8'h00);
    add_step("eoc byte 0 write", OP_WR, off_eoc, 4'h1, 32'h1122_3344, 32'h0, 8'h00);
    add_step("eoc byte 0 read", OP_RD, off_eoc, 4'hf, 32'h0, 32'hdead_be44, 8'h00);
    add_step("eoc bytes 1 2 write", OP_WR, off_eoc, 4'h6, 32'h5566_7788, 32'h0, 8'h00);
    add_step("eoc bytes 1 2 read", OP_RD, off_eoc, 4'hf, 32'h0, 32'hde66_7744, 8'h00);
    add_step("eoc byte 3 write", OP_WR, off_eoc, 4'h8, 32'haabb_ccdd, 32'h0, 8'h00);
    add_step("eoc no lane write", OP_WR, off_eoc, 4'h0, 32'hffff_ffff, 32'h0, 8'h00);
    add_step("eoc byte 3 read", OP_RD, off_eoc, 4'hf, 32'h0, 32'haa66_7744, 8'h00);
    add_step("eoc output", OP_EOC, off_eoc, 4'hf, 32'h0, 32'haa66_7744, 8'h00);
    // read-only words and offsets past the map
    add_step("tcdm_start write", OP_WR, off_start, 4'hf, 32'h0, 32'h0, 8'h00);
    add_step("tcdm_start read", OP_RD, off_start, 4'hf, 32'h0, exp_base, 8'h00);
    add_step("tcdm_end write", OP_WR, off_end, 4'hf, 32'hffff_ffff, 32'h0, 8'h00);
    add_step("tcdm_end read", OP_RD, off_end, 4'hf, 32'h0, exp_end, 8'h00);
    add_step("num_cores write", OP_WR, off_cores, 4'h3, 32'h0000_00ff, 32'h0, 8'h00);
    add_step("num_cores read", OP_RD, off_cores, 4'hf, 32'h0, exp_cores, 8'h00);
    add_step("offset 5 write", OP_WR, 6'd5, 4'hf, 32'h1234_5678, 32'h0, 8'h00);
    add_step("offset 5 read", OP_RD, 6'd5, 4'hf, 32'h0, 32'h0, 8'h00);
    add_step("offset 7 read", OP_RD, 6'd7, 4'hf, 32'h0, 32'h0, 8'h00);
    // 8 and 9 share low bits with eoc and wake_up
    add_step("offset 8 write", OP_WR, 6'd8, 4'hf, 32'h0, 32'h0, 8'h00);
    add_step("offset 9 write", OP_WR, 6'd9, 4'hf, 32'h3, 32'h0, 8'h00);
    add_step("offset 9 read", OP_RD, 6'd9, 4'hf, 32'h0, 32'h0, 8'h00);
    add_step("eoc after aliases", OP_RD, off_eoc, 4'hf, 32'h0, 32'haa66_7744, 8'h00);
    add_step("wake_up after aliases", OP_RD, off_wake, 4'hf, 32'h0, 32'h0, 8'h00);
    // wake decode with pending flags that accumulate until acknowledged
    add_step("wake core 3", OP_WAKE, off_wake, 4'hf, 32'h3, 32'h3, 8'h08);
    add_step("wake core 0", OP_WAKE, off_wake, 4'hf, 32'h0, 32'h0, 8'h09);
    add_step("wake core 7", OP_WAKE, off_wake, 4'hf, 32'h7, 32'h7, 8'h89);
    add_step("wake id 8", OP_WAKE, off_wake, 4'hf, 32'h8, 32'h8, 8'h89);
    add_step("wake upper set", OP_WAKE, off_wake, 4'hf, 32'h103, 32'h103, 8'h89);
    add_step("ack core 3", OP_ACK, off_wake, 4'hf, 32'h08, 32'h0, 8'h81);
    add_step("ack core 0", OP_ACK, off_wake, 4'hf, 32'h01, 32'h0, 8'h80);
    add_step("wake all", OP_WAKE, off_wake, 4'hf, 32'hffff_ffff, 32'hffff_ffff, 8'hff);
    add_step("ack low half", OP_ACK, off_wake, 4'hf, 32'h0f, 32'h0, 8'hf0);
    add_step("ack high half", OP_ACK, off_wake, 4'hf, 32'hf0, 32'h0, 8'h00);
    // with partial lanes the merged word is decoded and not the bus data
    add_step("wake byte 0", OP_WAKE, off_wake, 4'h1, 32'h5, 32'hffff_ff05, 8'h00);
    add_step("wake upper bytes", OP_WAKE, off_wake, 4'he, 32'h0, 32'h5, 8'h20);
    add_step("ack core 5", OP_ACK, off_wake, 4'hf, 32'h20, 32'h0, 8'h00);

    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;

    for (int i = 0; i < step_name.size(); i++) begin
      run_step(i);
    end
    random_wakes(num_random);

    // assertions of the last rising edge have settled by the falling edge
    @(negedge clk_i);
    if (cluster_ctrl_i.checker_i.fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      fail_run("an assertion in the bound checker failed");
    end
  end

endmodule

//--- bench/cluster_ctrl_checker.sv
// concurrent assertions on the Wishbone handshake and the wake path
// bound into cluster_ctrl so it can see the internal wake mask
// fail_count is read by the testbench

`include "ctrl_params.svh"

module cluster_ctrl_checker (
  input logic                       clk_i,
  input logic                       arst_n_i,
  input logic                       cyc_i,
  input logic                       stb_i,
  input logic                       ack_i,
  input logic [`CTRL_NUM_CORES-1:0] wake_mask_i,
  input logic [`CTRL_NUM_CORES-1:0] pending_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // number of assertion failures so far
  int unsigned fail_count = 0;

  // ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ack_i |=> !ack_i)
    else begin
      fail_count++;
      $error("wb_ack_o held high for more than one cycle");
    end

  // ack only answers a strobe seen on the previous edge
  ack_after_stb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ack_i |-> $past(cyc_i && stb_i))
    else begin
      fail_count++;
      $error("wb_ack_o without a preceding cyc and stb");
    end

  // decode yields one core, all cores or none
  mask_shape: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(wake_mask_i) || (wake_mask_i == '1))
    else begin
      fail_count++;
      $error("wake mask is neither one-hot nor all ones");
    end

  // a rising pending bit needs that bit in the previous mask
  pending_rise: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ((pending_i & ~$past(pending_i)) & ~$past(wake_mask_i)) == '0)
    else begin
      fail_count++;
      $error("pending flag set without a wake mask bit");
    end

endmodule

bind cluster_ctrl cluster_ctrl_checker checker_i (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .cyc_i       (wb_cyc_i),
  .stb_i       (wb_stb_i),
  .ack_i       (wb_ack_o),
  .wake_mask_i (wake_mask),
  .pending_i   (wake_pending_o)
);

//--- hdl/cluster_ctrl.sv
// top of the cluster control block
// the host reaches the registers over Wishbone classic; eoc_o shows the
// end-of-computation word, and wake_pending_o holds one wake flag per core
// which each core clears with its bit of wake_ack_i

`include "ctrl_params.svh"

module cluster_ctrl
  import ctrl_bus_pkg::*;
  import ctrl_core_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // Wishbone classic slave port
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [`CTRL_ADDR_WIDTH-1:0]   wb_adr_i,
  input  logic [`CTRL_DATA_WIDTH/8-1:0] wb_sel_i,
  input  logic [`CTRL_DATA_WIDTH-1:0]   wb_dat_i,
  output logic [`CTRL_DATA_WIDTH-1:0]   wb_dat_o,
  output logic                          wb_ack_o,
  // host and core side
  output logic [`CTRL_DATA_WIDTH-1:0]   eoc_o,
  input  core_mask_t                    wake_ack_i,
  output core_mask_t                    wake_pending_o
);

  reg_idx_e                    reg_idx;
  logic                        reg_valid;
  byte_en_t                    byte_en;
  logic [`CTRL_DATA_WIDTH-1:0] wdata;
  logic                        wr_strobe;
  logic [`CTRL_DATA_WIDTH-1:0] rdata;
  core_mask_t                  wake_mask;

  // bus decode and handshake
  wb_reg_slave wb_reg_slave_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .reg_idx_o   (reg_idx),
    .reg_valid_o (reg_valid),
    .byte_en_o   (byte_en),
    .wdata_o     (wdata),
    .wr_strobe_o (wr_strobe),
    .rdata_i     (rdata)
  );

  // register storage and wake decode
  ctrl_registers ctrl_registers_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .reg_idx_i   (reg_idx),
    .reg_valid_i (reg_valid),
    .byte_en_i   (byte_en),
    .wdata_i     (wdata),
    .wr_strobe_i (wr_strobe),
    .rdata_o     (rdata),
    .eoc_o       (eoc_o),
    .wake_mask_o (wake_mask)
  );

  // sticky wake flags toward the cores
  core_wake_unit core_wake_unit_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .wake_mask_i    (wake_mask),
    .wake_ack_i     (wake_ack_i),
    .wake_pending_o (wake_pending_o)
  );

endmodule

//--- hdl/core_wake_unit.sv
// per-core wake event flags
// a core that sleeps waits on its pending bit; the bit is set by the
// wake mask from the register file and stays set until the core raises
// its acknowledge, so no wake request is lost while a core is busy

`include "ctrl_params.svh"

module core_wake_unit
  import ctrl_core_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  // one-hot or all-ones, zero when no wake write is in flight
  input  core_mask_t wake_mask_i,
  // per-core acknowledge, may be held high
  input  core_mask_t wake_ack_i,
  output core_mask_t wake_pending_o
);

  core_mask_t pending_q;
  core_mask_t pending_d;

  // ack clears first, a new wake in the same cycle sets the bit again
  // so a wake that races its own ack is kept
  assign pending_d = (pending_q & ~wake_ack_i) | wake_mask_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  assign wake_pending_o = pending_q;

endmodule

//--- hdl/ctrl_registers.sv
// control register file of the cluster
// holds eoc and wake_up as read-write words and returns the TCDM bounds
// and the core count as constants; writes honor the byte enables and
// leave the read-only words alone
// a wake_up write is decoded one cycle later into a wake mask for the cores

`include "ctrl_params.svh"

module ctrl_registers
  import ctrl_bus_pkg::*;
  import ctrl_core_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  reg_idx_e                    reg_idx_i,
  input  logic                        reg_valid_i,
  input  byte_en_t                    byte_en_i,
  input  logic [`CTRL_DATA_WIDTH-1:0] wdata_i,
  input  logic                        wr_strobe_i,
  output logic [`CTRL_DATA_WIDTH-1:0] rdata_o,
  output logic [`CTRL_DATA_WIDTH-1:0] eoc_o,
  output core_mask_t                  wake_mask_o
);

  localparam int unsigned NumBytes = `CTRL_DATA_WIDTH / 8;

  // read-only contents
  localparam logic [`CTRL_DATA_WIDTH-1:0] TcdmStart = `CTRL_TCDM_BASE;
  localparam logic [`CTRL_DATA_WIDTH-1:0] TcdmEnd   = `CTRL_TCDM_BASE + `CTRL_TCDM_SIZE;
  localparam logic [`CTRL_DATA_WIDTH-1:0] NumCores  = `CTRL_NUM_CORES;

  logic [`CTRL_DATA_WIDTH-1:0] eoc_q;
  logic [`CTRL_DATA_WIDTH-1:0] wake_q;
  logic                        wr_eoc;
  logic                        wr_wake;
  logic                        wake_wr_q;
  wake_word_u                  wake_word;

  // replace only the enabled byte lanes of a word
  function automatic logic [`CTRL_DATA_WIDTH-1:0] merge_bytes(
    input logic [`CTRL_DATA_WIDTH-1:0] old_val,
    input logic [`CTRL_DATA_WIDTH-1:0] new_val,
    input byte_en_t                    be
  );
    logic [`CTRL_DATA_WIDTH-1:0] res;
    res = old_val;
    for (int b = 0; b < NumBytes; b++) begin
      if (be[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  // only the two read-write words accept data
  assign wr_eoc  = wr_strobe_i & reg_valid_i & (reg_idx_i == EOC);
  // any touched byte of wake_up counts as a wake request
  assign wr_wake = wr_strobe_i & reg_valid_i & (reg_idx_i == WAKE_UP) & (|byte_en_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eoc_q     <= '0;
      wake_q    <= '0;
      wake_wr_q <= 1'b0;
    end else begin
      if (wr_eoc) eoc_q <= merge_bytes(eoc_q, wdata_i, byte_en_i);
      if (wr_wake) wake_q <= merge_bytes(wake_q, wdata_i, byte_en_i);
      // one cycle late so the decode sees the updated word
      wake_wr_q <= wr_wake;
    end
  end

  // read mux, unused index codes read zero
  always_comb begin
    case (reg_idx_i)
      EOC:        rdata_o = eoc_q;
      WAKE_UP:    rdata_o = wake_q;
      TCDM_START: rdata_o = TcdmStart;
      TCDM_END:   rdata_o = TcdmEnd;
      NUM_CORES:  rdata_o = NumCores;
      default:    rdata_o = '0;
    endcase
  end

  // wake decode: all ones wakes everyone, a valid core id wakes that core
  // anything else wakes nobody
  assign wake_word.raw = wake_q;

  always_comb begin
    wake_mask_o = '0;
    if (wake_wr_q) begin
      if (wake_word.raw == '1) begin
        wake_mask_o = '1;
      end else if (wake_word.field.upper == '0 &&
                   32'(wake_word.field.core_id) < `CTRL_NUM_CORES) begin
        wake_mask_o = core_mask_t'(1) << wake_word.field.core_id;
      end
    end
  end

  assign eoc_o = eoc_q;

endmodule

//--- hdl/wb_reg_slave.sv
// Wishbone classic slave in front of the control registers
// every access is acknowledged one cycle after cyc and stb are seen,
// with no error or retry; the register index, byte enables and write data
// follow the held bus signals, the write strobe is high in the ack cycle
// read data is taken from the register file and held on wb_dat_o for the ack

`include "ctrl_params.svh"

module wb_reg_slave
  import ctrl_bus_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // Wishbone classic slave port
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [`CTRL_ADDR_WIDTH-1:0]  wb_adr_i,
  input  logic [`CTRL_DATA_WIDTH/8-1:0] wb_sel_i,
  input  logic [`CTRL_DATA_WIDTH-1:0]  wb_dat_i,
  output logic [`CTRL_DATA_WIDTH-1:0]  wb_dat_o,
  output logic                         wb_ack_o,
  // register file side
  output reg_idx_e                     reg_idx_o,
  output logic                         reg_valid_o,
  output byte_en_t                     byte_en_o,
  output logic [`CTRL_DATA_WIDTH-1:0]  wdata_o,
  output logic                         wr_strobe_o,
  input  logic [`CTRL_DATA_WIDTH-1:0]  rdata_i
);

  // byte address to word offset, the two low bits select a byte lane
  localparam int unsigned WordAdrWidth = `CTRL_ADDR_WIDTH - 2;

  logic [WordAdrWidth-1:0]     word_adr;
  logic                        req;
  logic                        ack_q;
  logic                        wr_strobe_q;
  logic [`CTRL_DATA_WIDTH-1:0] dat_q;

  assign word_adr = wb_adr_i[`CTRL_ADDR_WIDTH-1:2];

  // new request: master strobing and this slave not already answering
  // the ack cycle itself does not count, the master still holds stb there
  assign req = wb_cyc_i & wb_stb_i & ~ack_q;

  // offsets past the last register alias in the low bits
  // so the valid flag keeps them away from the register file
  assign reg_valid_o = (word_adr < `CTRL_NUM_REGS);
  assign reg_idx_o   = reg_idx_e'(word_adr[2:0]);

  // master holds sel and data until ack, so they are stable in the ack cycle
  assign byte_en_o = wb_sel_i;
  assign wdata_o   = wb_dat_i;

  // single-cycle ack and write strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q       <= 1'b0;
      wr_strobe_q <= 1'b0;
    end else begin
      ack_q       <= req;
      wr_strobe_q <= req & wb_we_i;
    end
  end

  // read capture on the edge that starts the ack cycle
  // out-of-range offsets read as zero
  always_ff @(posedge clk_i) begin
    if (req && !wb_we_i) begin
      dat_q <= reg_valid_o ? rdata_i : '0;
    end
  end

  assign wb_ack_o    = ack_q;
  assign wr_strobe_o = wr_strobe_q;
  assign wb_dat_o    = dat_q;

endmodule

//--- hdl/ctrl_core_pkg.sv
// core-side types of the cluster control block
// the core mask carries one bit per core between the register file and
// the wake unit; the wake word union lets the decoder look at the written
// wake_up value both as a raw word and as an upper field plus core id

`include "ctrl_params.svh"

package ctrl_core_pkg;

  // bits needed to name one core
  localparam int unsigned CoreIdWidth = $clog2(`CTRL_NUM_CORES);

  // one bit per core
  typedef logic [`CTRL_NUM_CORES-1:0] core_mask_t;

  // wake_up word split into a must-be-zero upper part and the core id
  typedef struct packed {
    logic [`CTRL_DATA_WIDTH-CoreIdWidth-1:0] upper;
    logic [CoreIdWidth-1:0]                  core_id;
  } wake_field_t;

  // raw view for the all-ones broadcast test
  // field view for picking a single core
  typedef union packed {
    logic [`CTRL_DATA_WIDTH-1:0] raw;
    wake_field_t                 field;
  } wake_word_u;

endpackage

//--- hdl/ctrl_bus_pkg.sv
// bus-side types of the cluster control block
// the register index is what the Wishbone slave hands to the register file
// after address decode, the byte enable mirrors wb_sel
// import with a wildcard in the module header where these are needed

`include "ctrl_params.svh"

package ctrl_bus_pkg;

  // word offsets of the register map
  // eoc and wake_up are read-write, the other three are constants
  typedef enum logic [2:0] {
    EOC        = 3'd0,
    WAKE_UP    = 3'd1,
    TCDM_START = 3'd2,
    TCDM_END   = 3'd3,
    NUM_CORES  = 3'd4
  } reg_idx_e;

  // one enable per byte lane of the data word
  typedef logic [`CTRL_DATA_WIDTH/8-1:0] byte_en_t;

endpackage

//--- hdl/ctrl_params.svh
// shared build-time constants of the cluster control block
// include this wherever a width, the register count or the TCDM layout
// is needed; the two packages and every RTL module pull it in the same way
// changing a value here changes it for the design and the testbench at once

`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// bus and register word width in bits
`define CTRL_DATA_WIDTH 32

// byte address width seen on the Wishbone bus
`define CTRL_ADDR_WIDTH 8

// number of word registers in the map, offsets 0 to 4
`define CTRL_NUM_REGS 5

// cores in the cluster, one wake flag each
`define CTRL_NUM_CORES 8

// first byte of the tightly coupled data memory
`define CTRL_TCDM_BASE 32'h1000_0000

// TCDM size in bytes, end address is base plus size
`define CTRL_TCDM_SIZE 32'h0002_0000

`endif
